//--- verilog/rf_pkg.sv
// Shared widths, address map, request and power-control structs and power state enum
`default_nettype none

package rf_pkg;

    // ------------------------------------------------------------------
    // Sizes and address map
    // ------------------------------------------------------------------

    // Number of register-file entries
    localparam int RF_DEPTH = 16;
    // Cycles for the power-enable chain to ripple through the array
    localparam int PG_CHAIN_DEPTH = 4;
    // Flops in the array reset synchronizer of the wrapper
    localparam int RST_SYNC_STAGES = 2;

    typedef logic [3:0]  rf_addr_t;
    typedef logic [28:0] rf_data_t;
    // Stored word with one spare bit on top that is always written as zero
    typedef logic [29:0] rf_word_t;
    typedef logic [6:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // Byte address of the control and status register
    localparam wb_addr_t CSR_ADDR = 7'h40;

    // ------------------------------------------------------------------
    // Request and control bundles
    // ------------------------------------------------------------------

    typedef struct packed {
        logic     en;
        rf_addr_t addr;
        rf_data_t data;
    } rf_wr_req_t;

    typedef struct packed {
        logic     en;
        rf_addr_t addr;
    } rf_rd_req_t;

    // Isolation is active high while power enable and array reset are active low
    // as on the array macro
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
        logic ip_reset_b;
    } pwr_ctl_t;

    typedef enum logic [2:0] {ON, ISOLATE, POWER_OFF, OFF, POWER_ON, RELEASE} pwr_state_e;

endpackage

`default_nettype wire

//--- verilog/rf_array_16x30.sv
// Behavioral 16x30 two-port storage array with output isolation and power-enable chain
`timescale 1ns/100ps
`default_nettype none

module rf_array_16x30 (
     input  logic               clk
    ,input  logic               rst_n
    ,input  logic               wr_en
    ,input  rf_pkg::rf_addr_t   wr_addr
    ,input  rf_pkg::rf_word_t   wr_word
    ,input  rf_pkg::rf_rd_req_t rd
    ,output rf_pkg::rf_word_t   dout
    ,input  logic               ip_reset_b
    ,input  logic               isol_en
    ,input  logic               pwr_enable_b_in
    ,output logic               pwr_enable_b_out
);

    import rf_pkg::*;

    rf_word_t                  mem [RF_DEPTH];
    rf_word_t                  dout_q;
    logic [PG_CHAIN_DEPTH-1:0] pg_chain;
    logic                      array_on;
    logic                      access_ok;

    // ------------------------------------------------------------------
    // Power-enable chain
    // ------------------------------------------------------------------

    // Each stage models one bank of sleep transistors switching in turn
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pg_chain <= '0;
        end else begin
            pg_chain <= {pg_chain[PG_CHAIN_DEPTH-2:0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = pg_chain[PG_CHAIN_DEPTH-1];

    // The array is usable only once every bank is switched on
    assign array_on  = !pwr_enable_b_in && !(|pg_chain);
    assign access_ok = array_on && ip_reset_b;

    // ------------------------------------------------------------------
    // Storage and read port
    // ------------------------------------------------------------------

    // Contents are not guaranteed across a power cycle
    always_ff @(posedge clk) begin
        if (wr_en && access_ok) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // One cycle of read latency and the output register clears in reset
    always_ff @(posedge clk) begin
        if (!ip_reset_b) begin
            dout_q <= '0;
        end else if (rd.en && access_ok) begin
            dout_q <= mem[rd.addr];
        end
    end

    // Clamp the output so a powered-down array cannot float the read bus
    assign dout = isol_en ? '0 : dout_q;

endmodule

`default_nettype wire

//--- verilog/rf_pg_16x29.sv
// Power-gated 16x29 register-file wrapper with array reset synchronizer
`timescale 1ns/100ps
`default_nettype none

module rf_pg_16x29 (
     input  logic               clk
    ,input  logic               rst_n
    ,input  rf_pkg::rf_wr_req_t wr
    ,input  rf_pkg::rf_rd_req_t rd
    ,output rf_pkg::rf_data_t   rdata
    ,input  rf_pkg::pwr_ctl_t   pwr
    ,output logic               pwr_enable_b_out
);

    import rf_pkg::*;

    logic [RST_SYNC_STAGES-1:0] rst_sync_q;
    logic                       ip_reset_b_sync;
    rf_word_t                   wr_word;
    rf_word_t                   rd_word;

    // ------------------------------------------------------------------
    // Array reset synchronizer
    // ------------------------------------------------------------------

    // The request from the power controller is sampled on clk
    // Release ripples through every stage before reaching the array
    // System reset starts in the released state like the controller does
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rst_sync_q <= '1;
        end else if (!pwr.ip_reset_b) begin
            rst_sync_q <= '0;
        end else begin
            rst_sync_q <= {rst_sync_q[RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign ip_reset_b_sync = rst_sync_q[RST_SYNC_STAGES-1];

    // ------------------------------------------------------------------
    // Data padding and array instance
    // ------------------------------------------------------------------

    // The spare top bit of the storage word is always written as zero
    assign wr_word = {1'b0, wr.data};

    rf_array_16x30 i_rf (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.wr_en            (wr.en)
        ,.wr_addr          (wr.addr)
        ,.wr_word          (wr_word)
        ,.rd               (rd)
        ,.dout             (rd_word)
        ,.ip_reset_b       (ip_reset_b_sync)
        ,.isol_en          (pwr.isol_en)
        ,.pwr_enable_b_in  (pwr.pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // Drop the spare bit on the way back
    assign rdata = rd_word[$bits(rf_data_t)-1:0];

endmodule

`default_nettype wire

//--- verilog/rf_pwr_ctrl.sv
// Power sequencing FSM for isolation, power enable and array reset
`timescale 1ns/100ps
`default_nettype none

module rf_pwr_ctrl (
     input  logic             clk
    ,input  logic             rst_n
    ,input  logic             pd_req
    ,input  logic             pwr_enable_b_out
    ,output rf_pkg::pwr_ctl_t pwr
    ,output logic             ready
);

    import rf_pkg::*;

    pwr_state_e                             state_q;
    pwr_state_e                             state_d;
    pwr_ctl_t                               pwr_d;
    logic [$clog2(RST_SYNC_STAGES+1)-1:0]   rel_cnt;

    // ------------------------------------------------------------------
    // Next-state logic
    // ------------------------------------------------------------------

    // Both power transitions wait on the chain feedback from the array
    always_comb begin
        state_d = state_q;
        case (state_q)
            ON:        if (pd_req) state_d = ISOLATE;
            ISOLATE:   state_d = POWER_OFF;
            POWER_OFF: if (pwr_enable_b_out) state_d = OFF;
            OFF:       if (!pd_req) state_d = POWER_ON;
            POWER_ON:  if (!pwr_enable_b_out) state_d = RELEASE;
            RELEASE: begin
                // Give the wrapper synchronizer time to let go of the array
                if (int'(rel_cnt) == RST_SYNC_STAGES - 1) begin
                    state_d = ON;
                end
            end
            default:   state_d = ON;
        endcase
    end

    // Isolation stays up for as long as any part of the array may be off
    always_comb begin
        pwr_d = '{isol_en: 1'b1, pwr_enable_b: 1'b0, ip_reset_b: 1'b1};
        case (state_d)
            ON:        pwr_d = '{isol_en: 1'b0, pwr_enable_b: 1'b0, ip_reset_b: 1'b1};
            ISOLATE:   pwr_d = '{isol_en: 1'b1, pwr_enable_b: 1'b0, ip_reset_b: 1'b1};
            POWER_OFF: pwr_d = '{isol_en: 1'b1, pwr_enable_b: 1'b1, ip_reset_b: 1'b1};
            OFF:       pwr_d = '{isol_en: 1'b1, pwr_enable_b: 1'b1, ip_reset_b: 1'b0};
            POWER_ON:  pwr_d = '{isol_en: 1'b1, pwr_enable_b: 1'b0, ip_reset_b: 1'b0};
            RELEASE:   pwr_d = '{isol_en: 1'b0, pwr_enable_b: 1'b0, ip_reset_b: 1'b1};
            default:   pwr_d = '{isol_en: 1'b1, pwr_enable_b: 1'b0, ip_reset_b: 1'b1};
        endcase
    end

    // ------------------------------------------------------------------
    // State and output registers
    // ------------------------------------------------------------------

    // Outputs are registered from the next state so the power pins never glitch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ON;
            pwr     <= '{isol_en: 1'b0, pwr_enable_b: 1'b0, ip_reset_b: 1'b1};
            ready   <= 1'b1;
        end else begin
            state_q <= state_d;
            pwr     <= pwr_d;
            ready   <= (state_d == ON);
        end
    end

    // Counts cycles spent in RELEASE and clears everywhere else
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rel_cnt <= '0;
        end else if (state_q == RELEASE) begin
            rel_cnt <= rel_cnt + 1'b1;
        end else begin
            rel_cnt <= '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rf_wb_slave.sv
// Wishbone classic slave with address decode, register-file requests and control register
`timescale 1ns/100ps
`default_nettype none

module rf_wb_slave (
     input  logic               clk
    ,input  logic               rst_n
    ,input  logic               cyc
    ,input  logic               stb
    ,input  logic               we
    ,input  rf_pkg::wb_addr_t   adr
    ,input  rf_pkg::wb_data_t   dat_w
    ,output rf_pkg::wb_data_t   dat_r
    ,output logic               ack
    ,output logic               err
    ,output rf_pkg::rf_wr_req_t wr
    ,output rf_pkg::rf_rd_req_t rd
    ,input  rf_pkg::rf_data_t   rdata
    ,output logic               pd_req
    ,input  logic               ready
);

    import rf_pkg::*;

    logic     req_new;
    logic     rf_hit;
    logic     csr_hit;
    logic     wr_en_q;
    logic     rd_en_q;
    logic     rd_wait_q;
    logic     rd_resp_q;
    rf_addr_t req_idx_q;
    rf_data_t req_data_q;
    wb_data_t csr_dat_q;

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------

    // A cycle is new only when the slave is idle and has not just answered
    assign req_new = cyc && stb && !ack && !err && !rd_wait_q;

    // The lower half of the map holds the entries and they must be word aligned
    assign rf_hit  = (adr[6] == 1'b0) && (adr[1:0] == 2'b00);
    assign csr_hit = (adr == CSR_ADDR);

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------

    // Every accepted cycle ends with exactly one single-cycle ack or err
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            err       <= 1'b0;
            wr_en_q   <= 1'b0;
            rd_en_q   <= 1'b0;
            rd_wait_q <= 1'b0;
            rd_resp_q <= 1'b0;
            pd_req    <= 1'b0;
        end else begin
            ack     <= 1'b0;
            err     <= 1'b0;
            wr_en_q <= 1'b0;
            rd_en_q <= 1'b0;
            if (rd_wait_q) begin
                // Array data lands together with this ack
                rd_wait_q <= 1'b0;
                ack       <= 1'b1;
            end else if (req_new) begin
                if (rf_hit && ready) begin
                    if (we) begin
                        wr_en_q <= 1'b1;
                        ack     <= 1'b1;
                    end else begin
                        rd_en_q   <= 1'b1;
                        rd_wait_q <= 1'b1;
                        rd_resp_q <= 1'b1;
                    end
                end else if (csr_hit) begin
                    rd_resp_q <= 1'b0;
                    ack       <= 1'b1;
                    if (we) begin
                        pd_req <= dat_w[0];
                    end
                end else begin
                    // Also covers entry accesses while the array is down
                    err <= 1'b1;
                end
            end
        end
    end

    // Request payload and the CSR snapshot are captured on acceptance
    always_ff @(posedge clk) begin
        if (req_new) begin
            req_idx_q  <= adr[5:2];
            req_data_q <= dat_w[$bits(rf_data_t)-1:0];
            csr_dat_q  <= wb_data_t'({ready, pd_req});
        end
    end

    assign wr = '{en: wr_en_q, addr: req_idx_q, data: req_data_q};
    assign rd = '{en: rd_en_q, addr: req_idx_q};

    // Entry reads are zero extended straight from the array output
    assign dat_r = rd_resp_q ? {3'b000, rdata} : csr_dat_q;

endmodule

`default_nettype wire

//--- verilog/rf_subsys_top.sv
// Top level joining the bus slave, power controller and register-file wrapper
`timescale 1ns/100ps
`default_nettype none

module rf_subsys_top (
     input  logic             clk
    ,input  logic             rst_n
    ,input  logic             cyc
    ,input  logic             stb
    ,input  logic             we
    ,input  rf_pkg::wb_addr_t adr
    ,input  rf_pkg::wb_data_t dat_w
    ,output rf_pkg::wb_data_t dat_r
    ,output logic             ack
    ,output logic             err
);

    import rf_pkg::*;

    rf_wr_req_t wr_req;
    rf_rd_req_t rd_req;
    rf_data_t   rdata;
    pwr_ctl_t   pwr_ctl;
    logic       pd_req;
    logic       ready;
    logic       pwr_enable_b_out;

    // ------------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------------

    rf_wb_slave i_wb_slave (
         .clk    (clk)
        ,.rst_n  (rst_n)
        ,.cyc    (cyc)
        ,.stb    (stb)
        ,.we     (we)
        ,.adr    (adr)
        ,.dat_w  (dat_w)
        ,.dat_r  (dat_r)
        ,.ack    (ack)
        ,.err    (err)
        ,.wr     (wr_req)
        ,.rd     (rd_req)
        ,.rdata  (rdata)
        ,.pd_req (pd_req)
        ,.ready  (ready)
    );

    // ------------------------------------------------------------------
    // Power sequencing and storage
    // ------------------------------------------------------------------

    // The chain output closes the loop from the array back to the FSM
    rf_pwr_ctrl i_pwr_ctrl (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.pd_req           (pd_req)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pwr              (pwr_ctl)
        ,.ready            (ready)
    );

    rf_pg_16x29 i_rf_pg (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.wr               (wr_req)
        ,.rd               (rd_req)
        ,.rdata            (rdata)
        ,.pwr              (pwr_ctl)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

`default_nettype wire

//--- testbench/rf_subsys_asserts.sv
// Concurrent assertions on bus handshake and power sequencing, and their bind to the top level
`timescale 1ns/100ps
`default_nettype none

module rf_subsys_asserts (
     input  logic               clk
    ,input  logic               rst_n
    ,input  logic               cyc
    ,input  logic               stb
    ,input  logic               ack
    ,input  logic               err
    ,input  rf_pkg::pwr_ctl_t   pwr_ctl
    ,input  rf_pkg::rf_rd_req_t rd_req
    ,input  logic               pwr_enable_b_out
);

    // Number of assertion failures seen so far, read by the testbench at the end
    int fail_count = 0;

    // ------------------------------------------------------------------
    // Bus handshake
    // ------------------------------------------------------------------

    ack_err_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ack && err))
        else begin
            $error("ack and err are high in the same cycle");
            fail_count++;
        end

    // A response may only answer a cycle that the host still holds
    resp_inside_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (ack || err) |-> (cyc && stb))
        else begin
            $error("ack or err is high while cyc or stb is low");
            fail_count++;
        end

    // ------------------------------------------------------------------
    // Power sequencing
    // ------------------------------------------------------------------

    // The chain output reports banks switched off, so outputs must be clamped
    isol_while_off: assert property (@(posedge clk) disable iff (!rst_n)
        pwr_enable_b_out |-> pwr_ctl.isol_en)
        else begin
            $error("Array power is off while isolation is low");
            fail_count++;
        end

    no_read_isolated: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req.en |-> !pwr_ctl.isol_en)
        else begin
            $error("Read enable reaches the array while isolation is high");
            fail_count++;
        end

endmodule

bind rf_subsys_top rf_subsys_asserts i_asserts (
     .clk              (clk)
    ,.rst_n            (rst_n)
    ,.cyc              (cyc)
    ,.stb              (stb)
    ,.ack              (ack)
    ,.err              (err)
    ,.pwr_ctl          (pwr_ctl)
    ,.rd_req           (rd_req)
    ,.pwr_enable_b_out (pwr_enable_b_out)
);

`default_nettype wire

//--- testbench/tb_rf_subsys.sv
// Testbench for the register-file subsystem with data-file stimulus and a random pass
`timescale 1ns/100ps
`default_nettype none

module tb_rf_subsys;

    import rf_pkg::*;

    localparam int    BUS_TIMEOUT = 16;
    localparam int    MAX_POLLS   = 40;
    localparam string DATA_FILE   = "testbench/rf_subsys_testdata.txt";

    logic     clk;
    logic     rst_n;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    logic     ack;
    logic     err;

    int       check_errors = 0;
    int       run_errors   = 0;
    int       cycle_count  = 0;
    int       cycle_limit  = 2000;
    integer   seed         = 32'h8d2;
    byte      op_q[$];
    wb_addr_t adr_q[$];
    wb_data_t val_q[$];
    // Last value written to each entry during the random pass
    rf_data_t ref_mem [RF_DEPTH];

    // ------------------------------------------------------------------
    // Clock, DUT and run limit
    // ------------------------------------------------------------------

    initial clk = 1'b0;
    always #10 clk = ~clk;

    rf_subsys_top i_dut (
         .clk   (clk)
        ,.rst_n (rst_n)
        ,.cyc   (cyc)
        ,.stb   (stb)
        ,.we    (we)
        ,.adr   (adr)
        ,.dat_w (dat_w)
        ,.dat_r (dat_r)
        ,.ack   (ack)
        ,.err   (err)
    );

    task automatic finish_run();
        int assert_errors;
        assert_errors = i_dut.i_asserts.fail_count;
        $display("Errors: %0d value checks, %0d run failures, %0d assertion failures",
                 check_errors, run_errors, assert_errors);
        if (check_errors + run_errors + assert_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles before the tests were done", cycle_count);
            run_errors++;
            finish_run();
        end
    end

    // ------------------------------------------------------------------
    // Bus access and checks
    // ------------------------------------------------------------------

    task automatic check_value(input wb_addr_t addr, input wb_data_t actual,
                               input wb_data_t expected);
        assert (actual == expected) else begin
            $display("CHECK FAILED: dat_r = %h, expected %h at adr %h", actual, expected, addr);
            check_errors++;
        end
    endtask

    // One Wishbone classic cycle, held until ack or err
    task automatic bus_access(input logic write, input wb_addr_t addr, input wb_data_t wdata,
                              input logic want_err, output wb_data_t rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(posedge clk);
        #2;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        // Responses are sampled on the falling edge, well clear of the DUT update
        @(negedge clk);
        while (!ack && !err && waited < BUS_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!ack && !err) begin
            $display("Bus cycle to adr %h got neither ack nor err within %0d cycles",
                     addr, BUS_TIMEOUT);
            run_errors++;
        end else begin
            rdata = dat_r;
            assert (err == want_err) else begin
                $display("CHECK FAILED: err = %h, expected %h at adr %h", err, want_err, addr);
                check_errors++;
            end
        end
        @(posedge clk);
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    // Writes the request bit, then polls until the powered bit reaches its target
    task automatic power_request(input wb_addr_t addr, input wb_data_t wdata,
                                 input logic want_powered);
        wb_data_t csr;
        int       polls;
        polls = 0;
        bus_access(1'b1, addr, wdata, 1'b0, csr);
        bus_access(1'b0, addr, '0, 1'b0, csr);
        while (csr[1] != want_powered && polls < MAX_POLLS) begin
            polls++;
            bus_access(1'b0, addr, '0, 1'b0, csr);
        end
        if (csr[1] != want_powered) begin
            $display("Powered bit did not reach %0d within %0d CSR polls", want_powered, MAX_POLLS);
            run_errors++;
        end else begin
            // Powered sits in bit 1 and the request bit reads back in bit 0
            check_value(addr, csr, {30'b0, want_powered, wdata[0]});
        end
    endtask

    // ------------------------------------------------------------------
    // Data file and random pass
    // ------------------------------------------------------------------

    task automatic load_op_list();
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] v;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the data file %s", DATA_FILE);
            run_errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h", op, a, v);
                    if (n == 3) begin
                        op_q.push_back(op);
                        adr_q.push_back(a[6:0]);
                        val_q.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_line(input byte op, input wb_addr_t addr, input wb_data_t val);
        wb_data_t rdata;
        case (op)
            "W": bus_access(1'b1, addr, val, 1'b0, rdata);
            "R": begin
                bus_access(1'b0, addr, '0, 1'b0, rdata);
                check_value(addr, rdata, val);
            end
            // Both directions must be refused
            "E": begin
                bus_access(1'b1, addr, val, 1'b1, rdata);
                bus_access(1'b0, addr, '0, 1'b1, rdata);
            end
            "D": power_request(addr, val, 1'b0);
            "U": power_request(addr, val, 1'b1);
            default: begin
                $display("Unknown operation %c in the data file", op);
                run_errors++;
            end
        endcase
    endtask

    task automatic random_pass();
        wb_data_t data;
        wb_data_t rdata;
        rf_addr_t idx;
        // Every entry gets a known value first so that all of them are read back
        for (int i = 0; i < RF_DEPTH; i++) begin
            data       = $random(seed);
            ref_mem[i] = data[28:0];
            bus_access(1'b1, wb_addr_t'(i * 4), data, 1'b0, rdata);
        end
        for (int n = 0; n < 32; n++) begin
            data         = $random(seed);
            idx          = rf_addr_t'($random(seed));
            ref_mem[idx] = data[28:0];
            bus_access(1'b1, {1'b0, idx, 2'b00}, data, 1'b0, rdata);
        end
        // Bits 31:29 of the bus word never reach storage
        for (int i = 0; i < RF_DEPTH; i++) begin
            bus_access(1'b0, wb_addr_t'(i * 4), '0, 1'b0, rdata);
            check_value(wb_addr_t'(i * 4), rdata, {3'b000, ref_mem[i]});
        end
    endtask

    initial begin
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        load_op_list();
        cycle_limit = 200 * op_q.size() + 2000;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        foreach (op_q[i]) begin
            run_line(op_q[i], adr_q[i], val_q[i]);
        end
        // Array has to be up before the random pass
        power_request(CSR_ADDR, 32'h0, 1'b1);
        random_pass();
        finish_run();
    end

endmodule

`default_nettype wire

//--- testbench/rf_subsys_testdata.txt
# op adr value, all hex. W write, R read and compare, E err on write and read,
# D power-down request and poll, U power-up request and poll
R 40 00000002
W 00 00000001
W 04 12345678
W 08 FFFFFFFF
W 0C 1ABCDEF0
W 3C E0000005
R 00 00000001
R 04 12345678
R 08 1FFFFFFF
R 0C 1ABCDEF0
R 3C 00000005
W 04 0000BEEF
R 04 0000BEEF
W 40 00000002
R 40 00000002
E 02 00000000
E 3D 00000000
E 44 00000000
E 7C 00000000
D 40 00000001
R 40 00000001
E 10 00000055
W 40 00000001
U 40 00000000
R 40 00000002
W 20 0F0F0F0F
R 20 0F0F0F0F

//--- project.f
verilog/rf_pkg.sv
verilog/rf_array_16x30.sv
verilog/rf_pg_16x29.sv
verilog/rf_pwr_ctrl.sv
verilog/rf_wb_slave.sv
verilog/rf_subsys_top.sv
testbench/rf_subsys_asserts.sv
testbench/tb_rf_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Builds the register-file subsystem testbench with Verilator, runs it and checks the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_rf_subsys -f project.f \
    && ./obj_dir/Vtb_rf_subsys +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation broke off"; exit 1; }

cat sim.log

grep -q "Test failed" sim.log && exit 1 || exit 0
